// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_conv_top
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert -j 0

SRCS := $(filter-out +incdir+%,$(shell cat $(FLIST)))
HDRS := $(wildcard common/*.svh)
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run check clean

all: check

build: $(BIN)

$(BIN): $(FLIST) $(SRCS) $(HDRS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR) -o V$(TOP)

run: $(BIN)
	$(BIN) > $(LOG) 2>&1 || echo "simulator exited with an error" >> $(LOG)
	cat $(LOG)

check: run
	@if grep -q '>>> FAIL' $(LOG); then echo "simulation failed"; exit 1; fi
	@if grep -q 'exited with an error' $(LOG); then echo "simulation failed"; exit 1; fi
	@echo "simulation passed"

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== common/conv_regs_pkg.sv ====
`include "conv_settings.svh"

package conv_regs_pkg;

  // decoded apb target
  typedef enum logic [2:0] {
    REG_NONE,    // unmapped, answers with pslverr
    REG_CTRL,
    REG_WSET,
    REG_STATUS,
    REG_RES0,
    REG_RES1,
    REG_WIN,     // one of the nine window words
    REG_WGT      // weight region, valid tap
  } reg_sel_e;

  typedef struct packed {
    logic [`CONV_APB_DW-3:0] rsvd;  // reads as 0
    logic                    done;  // bit 1, sticky until next start
    logic                    busy;  // bit 0
  } status_t;

  typedef struct packed {
    logic [`CONV_APB_DW-2:0] rsvd;
    logic                    start; // bit 0, self clearing
  } ctrl_t;

endpackage

// ==== common/conv_settings.svh ====
`ifndef CONV_SETTINGS_SVH
`define CONV_SETTINGS_SVH

// datapath sizes
`define CONV_DATA_W        8       // pixel and weight width
`define CONV_CIN_NUM       4       // input channels per tap
`define CONV_COUT_NUM      2       // output channels
`define CONV_K_DIM         3       // kernel rows and columns
`define CONV_TAP_NUM       9       // kernel taps
`define CONV_ACC_W         32      // accumulator width

// tap ram geometry
`define CONV_WR_W          32      // write word, one cout worth of weights
`define CONV_RD_W          64      // read word, both couts
`define CONV_SET_NUM       16      // weight sets, rows of the read port
`define CONV_RD_AW         4       // read address bits
`define CONV_WR_AW         5       // write address bits, lsb picks the half

// apb map
`define CONV_APB_AW        12
`define CONV_APB_DW        32
`define CONV_REG_CTRL      12'h000 // bit 0 start
`define CONV_REG_WSET      12'h004 // weight set for the next start
`define CONV_REG_STATUS    12'h008 // bit 0 busy, bit 1 done
`define CONV_REG_RES0      12'h00C // cout 0 sum
`define CONV_REG_RES1      12'h010 // cout 1 sum
`define CONV_REG_WIN_BASE  12'h020 // nine pixel words
`define CONV_WGT_BASE      12'h800 // write-only weight region

`endif

// ==== common/conv_types_pkg.sv ====
`include "conv_settings.svh"

package conv_types_pkg;

  typedef logic signed [`CONV_DATA_W-1:0] pixel_t;   // one feature pixel
  typedef logic signed [`CONV_DATA_W-1:0] weight_t;  // one kernel weight

  // weight write word: apb sees raw bits, the mac array sees lanes
  typedef union packed {
    logic [`CONV_WR_W-1:0]       raw;   // as written into the ram
    weight_t [`CONV_CIN_NUM-1:0] lane;  // lane n belongs to input channel n
  } wgt_word_u;

  // tap ram read word, index 0 is cout 0 (low half)
  typedef wgt_word_u [`CONV_RD_W/`CONV_WR_W-1:0] tap_rd_t;

  // window storage
  typedef pixel_t [`CONV_CIN_NUM-1:0] pix_word_t;    // all cin of one tap
  typedef pix_word_t [`CONV_TAP_NUM-1:0] window_t;   // tap 0 in the low word

  typedef logic signed [`CONV_ACC_W-1:0] acc_t;      // raw convolution sum

endpackage

// ==== common/weight_buf_if.sv ====
`timescale 1ns/1ps
`include "conv_settings.svh"

interface weight_buf_if
  import conv_types_pkg::*;
();

  logic [`CONV_TAP_NUM-1:0] tap_wr;                // one-hot tap write strobe
  logic [`CONV_WR_AW-1:0]   wr_addr;               // {set, cout half}
  wgt_word_u                wr_data;
  logic [`CONV_RD_AW-1:0]   rd_addr;               // weight set
  tap_rd_t [`CONV_TAP_NUM-1:0] rd_data;            // all taps, tap 0 low

  modport writer (output tap_wr, output wr_addr, output wr_data);
  modport reader (output rd_addr, input rd_data);
  modport buffer (input tap_wr, input wr_addr, input wr_data, input rd_addr,
                  output rd_data);

endinterface

// ==== flist.f ====
+incdir+common
common/conv_types_pkg.sv
common/conv_regs_pkg.sv
common/weight_buf_if.sv
weight_buffer/weight_tap_ram.sv
weight_buffer/weight_buffer.sv
hw/conv_apb_regs.sv
hw/conv_mac_array.sv
hw/conv_top.sv
testbench/tb_clk_gen.sv
testbench/tb_conv_top.sv

// ==== hw/conv_apb_regs.sv ====
`timescale 1ns/1ps
`include "conv_settings.svh"

module conv_apb_regs
  import conv_types_pkg::*;
  import conv_regs_pkg::*;
(
  input  logic                    clk,
  input  logic                    arst_n,
  input  logic                    psel,
  input  logic                    penable,
  input  logic                    pwrite,
  input  logic [`CONV_APB_AW-1:0] paddr,
  input  logic [`CONV_APB_DW-1:0] pwdata,
  output logic [`CONV_APB_DW-1:0] prdata,
  output logic                    pready,
  output logic                    pslverr,
  weight_buf_if.writer            wbuf,
  output logic                    start,      // one cycle pulse to the mac array
  output logic [`CONV_RD_AW-1:0]  wset,
  output window_t                 window,
  input  logic                    busy,       // mac pipeline occupied
  input  logic                    done,       // pulse, results valid
  input  acc_t                    res0,
  input  acc_t                    res1
);

  reg_sel_e                sel;       // decoded target of paddr
  logic [`CONV_APB_AW-1:0] win_off;   // byte offset into the window block
  logic [`CONV_APB_AW-1:0] wgt_off;   // byte offset into the weight region
  logic [3:0]              win_idx;   // window word
  logic [3:0]              tap_idx;   // word index bits 8:5
  logic                    acc;       // apb access cycle
  logic                    err;
  logic                    wr_ok;     // write that may change state
  ctrl_t                   ctrl;
  status_t                 status;
  logic                    done_q;
  acc_t                    res0_q;
  acc_t                    res1_q;

  assign win_off = paddr - `CONV_REG_WIN_BASE;  // wraps high below the base
  assign wgt_off = paddr - `CONV_WGT_BASE;
  assign win_idx = win_off[5:2];
  assign tap_idx = wgt_off[10:7];

  // address decode, full match for the small registers
  always_comb begin
    sel = REG_NONE;
    if (paddr >= `CONV_WGT_BASE) begin
      if (tap_idx < `CONV_TAP_NUM)
        sel = REG_WGT;                           // taps 9..15 stay unmapped
    end else if (paddr[1:0] == 2'b00) begin
      case (paddr)
        `CONV_REG_CTRL:   sel = REG_CTRL;
        `CONV_REG_WSET:   sel = REG_WSET;
        `CONV_REG_STATUS: sel = REG_STATUS;
        `CONV_REG_RES0:   sel = REG_RES0;
        `CONV_REG_RES1:   sel = REG_RES1;
        default: begin
          if (win_off < 4 * `CONV_TAP_NUM)
            sel = REG_WIN;
        end
      endcase
    end
  end

  assign acc     = psel & penable;
  assign err     = (sel == REG_NONE) | ((sel == REG_WGT) & ~pwrite);  // weights write-only
  assign wr_ok   = acc & pwrite & ~err;
  assign ctrl    = ctrl_t'(pwdata);
  assign pready  = 1'b1;                         // never waits
  assign pslverr = acc & err;

  // weight writes go straight to the tap rams
  always_comb begin
    wbuf.tap_wr = '0;
    if (wr_ok && sel == REG_WGT)
      wbuf.tap_wr[tap_idx] = 1'b1;
  end
  assign wbuf.wr_addr  = wgt_off[6:2];           // {set, cout half}
  assign wbuf.wr_data.raw = pwdata;

  // start counts as busy until the mac pipeline takes over
  always_comb begin
    status      = '0;
    status.busy = busy | start;
    status.done = done_q;
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      start  <= 1'b0;
      wset   <= '0;
      window <= '0;
      done_q <= 1'b0;
      res0_q <= '0;
      res1_q <= '0;
    end else begin
      start <= wr_ok && (sel == REG_CTRL) && ctrl.start && !status.busy;  // drop while busy
      if (wr_ok && sel == REG_WSET)
        wset <= pwdata[`CONV_RD_AW-1:0];
      if (wr_ok && sel == REG_WIN)
        window[win_idx] <= pwdata;
      if (start)
        done_q <= 1'b0;                          // accepted start clears done
      else if (done)
        done_q <= 1'b1;
      if (done) begin
        res0_q <= res0;                          // hold until next done
        res1_q <= res1;
      end
    end
  end

  // read mux, weight region and ctrl read back as 0
  always_comb begin
    prdata = '0;
    case (sel)
      REG_WSET:   prdata[`CONV_RD_AW-1:0] = wset;
      REG_STATUS: prdata = status;
      REG_RES0:   prdata = res0_q;
      REG_RES1:   prdata = res1_q;
      REG_WIN:    prdata = window[win_idx];
      default:    prdata = '0;
    endcase
  end

endmodule

// ==== hw/conv_mac_array.sv ====
`timescale 1ns/1ps
`include "conv_settings.svh"

module conv_mac_array
  import conv_types_pkg::*;
(
  input  logic                   clk,
  input  logic                   arst_n,
  input  logic                   start,     // cycle 0
  input  logic [`CONV_RD_AW-1:0] wset,
  input  window_t                window,
  weight_buf_if.reader           wbuf,
  output logic                   busy,      // cycles 1..3
  output logic                   done,      // cycle 3
  output acc_t                   res0,
  output acc_t                   res1
);

  logic [`CONV_RD_AW-1:0] set_q;            // set latched at start
  logic                   s1_vld;           // cycle 1, rd_data valid
  logic                   s2_vld;           // cycle 2, tap sums registered

  acc_t tap_sum_d [`CONV_TAP_NUM][`CONV_COUT_NUM];  // per tap, per cout
  acc_t tap_sum_q [`CONV_TAP_NUM][`CONV_COUT_NUM];
  acc_t res_d     [`CONV_COUT_NUM];
  acc_t res_q     [`CONV_COUT_NUM];

  // 8x8 signed product widened to the accumulator
  function automatic acc_t mul_ext(pixel_t px, weight_t wt);
    logic signed [2*`CONV_DATA_W-1:0] prod;
    prod = px * wt;
    return acc_t'(prod);
  endfunction

  // ram samples the set in cycle 0 already, so data shows up in cycle 1
  assign wbuf.rd_addr = start ? wset : set_q;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      set_q  <= '0;
      s1_vld <= 1'b0;
      s2_vld <= 1'b0;
      done   <= 1'b0;
    end else begin
      if (start)
        set_q <= wset;
      s1_vld <= start;
      s2_vld <= s1_vld;
      done   <= s2_vld;                    // res_q valid from here on
    end
  end

  assign busy = s1_vld | s2_vld | done;

  // stage 1, four cin products per tap and cout
  always_comb begin
    for (int t = 0; t < `CONV_TAP_NUM; t++) begin
      for (int c = 0; c < `CONV_COUT_NUM; c++) begin
        tap_sum_d[t][c] = '0;
        for (int ci = 0; ci < `CONV_CIN_NUM; ci++) begin
          tap_sum_d[t][c] += mul_ext(window[t][ci], wbuf.rd_data[t][c].lane[ci]);
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (s1_vld)
      tap_sum_q <= tap_sum_d;
  end

  // stage 2, add the nine tap sums per cout
  always_comb begin
    for (int c = 0; c < `CONV_COUT_NUM; c++) begin
      res_d[c] = '0;
      for (int t = 0; t < `CONV_TAP_NUM; t++) begin
        res_d[c] += tap_sum_q[t][c];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (s2_vld)
      res_q <= res_d;
  end

  assign res0 = res_q[0];
  assign res1 = res_q[1];

endmodule

// ==== hw/conv_top.sv ====
`timescale 1ns/1ps
`include "conv_settings.svh"

module conv_top
  import conv_types_pkg::*;
(
  input  logic                    clk,
  input  logic                    arst_n,
  input  logic                    psel,
  input  logic                    penable,
  input  logic                    pwrite,
  input  logic [`CONV_APB_AW-1:0] paddr,
  input  logic [`CONV_APB_DW-1:0] pwdata,
  output logic [`CONV_APB_DW-1:0] prdata,
  output logic                    pready,
  output logic                    pslverr
);

  logic                   start;
  logic [`CONV_RD_AW-1:0] wset;
  window_t                window;
  logic                   busy;
  logic                   done;
  acc_t                   res0;
  acc_t                   res1;

  weight_buf_if i_wbuf ();                 // regs write, mac reads

  conv_apb_regs i_regs (
    .clk     (clk),
    .arst_n  (arst_n),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .paddr   (paddr),
    .pwdata  (pwdata),
    .prdata  (prdata),
    .pready  (pready),
    .pslverr (pslverr),
    .wbuf    (i_wbuf.writer),
    .start   (start),
    .wset    (wset),
    .window  (window),
    .busy    (busy),
    .done    (done),
    .res0    (res0),
    .res1    (res1)
  );

  weight_buffer i_wbuffer (
    .clk  (clk),
    .wbuf (i_wbuf.buffer)
  );

  conv_mac_array i_mac (
    .clk    (clk),
    .arst_n (arst_n),
    .start  (start),
    .wset   (wset),
    .window (window),
    .wbuf   (i_wbuf.reader),
    .busy   (busy),
    .done   (done),
    .res0   (res0),
    .res1   (res1)
  );

endmodule

// ==== testbench/tb_clk_gen.sv ====
`timescale 1ns/1ps

module tb_clk_gen (
  output logic clk,
  output logic arst_n
);

  localparam int HALF_PERIOD = 20;  // 40 ns period
  localparam int RST_CYCLES  = 3;

  initial begin
    clk = 1'b0;
    forever #HALF_PERIOD clk = ~clk;
  end

  initial begin
    arst_n = 1'b0;
    repeat (RST_CYCLES) @(posedge clk);
    #2 arst_n = 1'b1;  // released off the edge like the other inputs
  end

endmodule

// ==== testbench/tb_conv_top.sv ====
`timescale 1ns/1ps
`include "conv_settings.svh"

module tb_conv_top
  import conv_regs_pkg::*;
;

  logic        clk;
  logic        arst_n;
  logic        psel;
  logic        penable;
  logic        pwrite;
  logic [11:0] paddr;
  logic [31:0] pwdata;
  logic [31:0] prdata;
  logic        pready;
  logic        pslverr;

  int chk_cnt;                            // checks done
  int err_cnt;                            // wrong values
  int tmo_cnt;                            // waits that ran out

  logic [31:0] wgt_model [16][9][2];      // set, tap, cout half
  logic [31:0] win_model [9];             // four pixels per tap

  tb_clk_gen i_clk_gen (.clk(clk), .arst_n(arst_n));

  conv_top i_dut (
    .clk     (clk),
    .arst_n  (arst_n),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .paddr   (paddr),
    .pwdata  (pwdata),
    .prdata  (prdata),
    .pready  (pready),
    .pslverr (pslverr)
  );

  task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
    chk_cnt++;
    assert (act === exp) else begin
      err_cnt++;
      $display("FAIL %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  // one apb3 transfer, sampled mid access cycle
  task automatic apb_xfer(input logic wr, input logic [11:0] addr, input logic [31:0] wdata,
                          output logic [31:0] rdata, output logic slverr);
    int waits;
    @(posedge clk);
    #2;
    psel    = 1'b1;                       // setup
    penable = 1'b0;
    pwrite  = wr;
    paddr   = addr;
    pwdata  = wdata;
    @(posedge clk);
    #2;
    penable = 1'b1;                       // access
    waits   = 0;
    @(negedge clk);
    while (pready !== 1'b1 && waits < 10) begin
      @(negedge clk);
      waits++;
    end
    if (pready !== 1'b1) begin
      tmo_cnt++;
      $display("apb access to %h never saw pready", addr);
    end
    rdata  = prdata;
    slverr = pslverr;
    @(posedge clk);
    #2;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic apb_write(input logic [11:0] addr, input logic [31:0] data, output logic slverr);
    logic [31:0] unused;
    apb_xfer(1'b1, addr, data, unused, slverr);
  endtask

  task automatic apb_read(input logic [11:0] addr, output logic [31:0] data, output logic slverr);
    apb_xfer(1'b0, addr, 32'h0, data, slverr);
  endtask

  // write that must be accepted
  task automatic write_reg(input string name, input logic [11:0] addr, input logic [31:0] data);
    logic err;
    apb_write(addr, data, err);
    check_val({name, " pslverr"}, 32'h0, {31'h0, err});
  endtask

  // read that must be accepted
  task automatic read_reg(input string name, input logic [11:0] addr, output logic [31:0] data);
    logic err;
    apb_read(addr, data, err);
    check_val({name, " pslverr"}, 32'h0, {31'h0, err});
  endtask

  function automatic logic [11:0] wgt_addr(input int tap, input int set, input int half);
    return `CONV_WGT_BASE + 12'(tap * 128 + set * 8 + half * 4);  // index {tap, set, half}
  endfunction

  task automatic write_weight(input string name, input int set, input int tap, input int half,
                              input logic [31:0] data);
    write_reg(name, wgt_addr(tap, set, half), data);
    wgt_model[set][tap][half] = data;
  endtask

  task automatic load_set(input string name, input int set);
    for (int t = 0; t < 9; t++)
      for (int h = 0; h < 2; h++)
        write_weight(name, set, t, h, $urandom());
  endtask

  task automatic load_window(input string name);
    for (int t = 0; t < 9; t++) begin
      win_model[t] = $urandom();
      write_reg(name, `CONV_REG_WIN_BASE + 12'(4 * t), win_model[t]);
    end
  endtask

  // pixel times weight over taps and input channels
  function automatic int expected_sum(input int set, input int cout);
    int acc;
    logic signed [7:0] px;
    logic signed [7:0] wt;
    acc = 0;
    for (int t = 0; t < 9; t++) begin
      for (int ci = 0; ci < 4; ci++) begin
        px  = win_model[t][8*ci +: 8];
        wt  = wgt_model[set][t][cout][8*ci +: 8];
        acc = acc + int'(px) * int'(wt);
      end
    end
    return acc;
  endfunction

  task automatic wait_done(input string name);
    logic [31:0] rd;
    status_t     st;
    int          polls;
    polls = 0;
    st    = '0;
    while (!st.done && polls < 20) begin
      read_reg(name, `CONV_REG_STATUS, rd);
      st = status_t'(rd);
      polls++;
    end
    if (!st.done) begin
      tmo_cnt++;
      $display("%s: STATUS.done never came up within 20 reads", name);
    end
  endtask

  task automatic run_conv(input string name, input int set,
                          output logic [31:0] r0, output logic [31:0] r1);
    write_reg(name, `CONV_REG_WSET, set);
    write_reg(name, `CONV_REG_CTRL, 32'h1);
    wait_done(name);
    read_reg(name, `CONV_REG_RES0, r0);
    read_reg(name, `CONV_REG_RES1, r1);
  endtask

  task automatic check_conv(input string name, input int set,
                            output logic [31:0] r0, output logic [31:0] r1);
    run_conv(name, set, r0, r1);
    check_val({name, " res0"}, expected_sum(set, 0), r0);
    check_val({name, " res1"}, expected_sum(set, 1), r1);
  endtask

  task automatic reset_values();
    logic [31:0] rd;
    read_reg("reset status", `CONV_REG_STATUS, rd);
    check_val("reset status", 32'h0, rd);
    read_reg("reset res0", `CONV_REG_RES0, rd);
    check_val("reset res0", 32'h0, rd);
    read_reg("reset res1", `CONV_REG_RES1, rd);
    check_val("reset res1", 32'h0, rd);
  endtask

  task automatic reg_readback();
    logic [31:0] val;
    logic [31:0] rd;
    val = $urandom() & 32'hF;             // wset keeps 4 bits
    write_reg("wset readback", `CONV_REG_WSET, val);
    read_reg("wset readback", `CONV_REG_WSET, rd);
    check_val("wset readback", val, rd);
    load_window("window readback");
    for (int t = 0; t < 9; t++) begin
      read_reg("window readback", `CONV_REG_WIN_BASE + 12'(4 * t), rd);
      check_val($sformatf("window %0d readback", t), win_model[t], rd);
    end
  endtask

  task automatic conv_set3();
    logic [31:0] r0;
    logic [31:0] r1;
    load_set("set3 load", 3);
    load_window("set3 window");
    check_conv("set3 conv", 3, r0, r1);
  endtask

  task automatic set_switch();
    logic [31:0] r0;
    logic [31:0] r1;
    logic [31:0] new_w;
    load_set("set9 load", 9);
    check_conv("switch set3", 3, r0, r1);
    check_conv("switch set9", 9, r0, r1);
    new_w = wgt_model[9][4][1] ^ ($urandom() | 32'h1);  // always a different word
    write_weight("set9 rewrite", 9, 4, 1, new_w);
    run_conv("set9 rewrite", 9, r0, r1);
    check_val("set9 rewrite res0 kept", expected_sum(9, 0), r0);
    check_val("set9 rewrite res1", expected_sum(9, 1), r1);
  endtask

  task automatic error_response();
    logic [31:0] rd;
    logic [31:0] r0;
    logic [31:0] r1;
    logic        err;
    apb_read(12'h014, rd, err);           // hole between res1 and window
    check_val("unmapped pslverr", 32'h1, {31'h0, err});
    apb_write(wgt_addr(9, 9, 0), $urandom(), err);
    check_val("tap9 write pslverr", 32'h1, {31'h0, err});
    check_conv("tap9 write no effect", 9, r0, r1);
    apb_read(wgt_addr(2, 3, 1), rd, err);
    check_val("weight read pslverr", 32'h1, {31'h0, err});
  endtask

  task automatic restart_clears_done();
    logic [31:0] rd;
    logic [31:0] r0;
    logic [31:0] r1;
    status_t     st;
    read_reg("restart", `CONV_REG_STATUS, rd);
    st = status_t'(rd);
    check_val("restart done before", 32'h1, {31'h0, st.done});
    write_reg("restart", `CONV_REG_CTRL, 32'h1);
    read_reg("restart", `CONV_REG_STATUS, rd);
    st = status_t'(rd);
    check_val("restart done cleared", 32'h0, {31'h0, st.done});
    wait_done("restart");
    read_reg("restart", `CONV_REG_RES0, r0);
    read_reg("restart", `CONV_REG_RES1, r1);
    check_val("restart res0", expected_sum(9, 0), r0);
    check_val("restart res1", expected_sum(9, 1), r1);
  endtask

  initial begin
    int rst_wait;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = '0;
    pwdata  = '0;
    chk_cnt = 0;
    err_cnt = 0;
    tmo_cnt = 0;
    void'($urandom(7));
    rst_wait = 0;
    while (!arst_n && rst_wait < 10) begin
      @(posedge clk);
      rst_wait++;
    end
    if (!arst_n) begin
      tmo_cnt++;
      $display("reset was never released");
    end
    reset_values();
    reg_readback();
    conv_set3();
    set_switch();
    error_response();
    restart_clears_done();
    $display("checks %0d, errors %0d, timeouts %0d", chk_cnt, err_cnt, tmo_cnt);
    if (err_cnt == 0 && tmo_cnt == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

// ==== weight_buffer/weight_buffer.sv ====
`timescale 1ns/1ps
`include "conv_settings.svh"

module weight_buffer
  import conv_types_pkg::*;
(
  input  logic         clk,
  weight_buf_if.buffer wbuf
);

  // read words of one kernel row, column 0 in the low slot
  tap_rd_t [`CONV_K_DIM-1:0] row_rd [`CONV_K_DIM];

  generate
    for (genvar r = 0; r < `CONV_K_DIM; r++) begin : g_row      // kernel rows 0..2
      for (genvar c = 0; c < `CONV_K_DIM; c++) begin : g_tap    // taps within the row
        weight_tap_ram i_ram (
          .clk     (clk),
          .wr_en   (wbuf.tap_wr[r*`CONV_K_DIM + c]),            // own strobe per tap
          .wr_addr (wbuf.wr_addr),                              // shared write side
          .wr_data (wbuf.wr_data),
          .rd_addr (wbuf.rd_addr),                              // every tap reads the same set
          .rd_data (row_rd[r][c])
        );
      end
    end
  endgenerate

  // rows stacked so that tap r*3+c lands at rd_data index r*3+c
  assign wbuf.rd_data = {row_rd[2], row_rd[1], row_rd[0]};

endmodule

// ==== weight_buffer/weight_tap_ram.sv ====
`timescale 1ns/1ps
`include "conv_settings.svh"

module weight_tap_ram
  import conv_types_pkg::*;
(
  input  logic                   clk,
  input  logic                   wr_en,
  input  logic [`CONV_WR_AW-1:0] wr_addr,   // {row, half}
  input  wgt_word_u              wr_data,   // one cout worth of weights
  input  logic [`CONV_RD_AW-1:0] rd_addr,   // write address without its lsb
  output tap_rd_t                rd_data    // both couts, registered
);

  // 16 x 64, each row holds both cout halves of one weight set
  tap_rd_t mem [`CONV_SET_NUM];

  logic [`CONV_RD_AW-1:0] wr_row;           // row of the write
  logic                   wr_half;          // 0 low half (cout 0), 1 high half

  assign wr_row  = wr_addr[`CONV_WR_AW-1:1];
  assign wr_half = wr_addr[0];

  // narrow write port, only the addressed half changes
  always_ff @(posedge clk) begin
    if (wr_en)
      mem[wr_row][wr_half] <= wr_data;
  end

  // wide read port, one cycle latency like block ram
  always_ff @(posedge clk) begin
    rd_data <= mem[rd_addr];
  end

endmodule
